//--- sim.f
+incdir+rtl
rtl/ssb_sync_pkg.sv
rtl/sss_if.sv
rtl/pss_detector.sv
rtl/frame_sync.sv
rtl/sss_collector.sv
rtl/ssb_sync_top.sv
dv/ssb_sync_checker.sv
dv/ssb_sync_tb.sv

//--- Bender.yml
package:
  name: ssb_sync

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ssb_sync_pkg.sv
      - rtl/sss_if.sv
      - rtl/pss_detector.sv
      - rtl/frame_sync.sv
      - rtl/sss_collector.sv
      - rtl/ssb_sync_top.sv
      - target: test
        files:
          - dv/ssb_sync_checker.sv
          - dv/ssb_sync_tb.sv

//--- dv/ssb_sync_tests.txt
# tokens: test <name> | seq <count> <sign bits, first sample in bit 0> <magnitude> <imag>
# exp <sss word> <nid2>; seq sample re is +magnitude where its bit is 1, else -magnitude; hex
test pat0_detect seq 32 9ac60000 0400 0123 seq 24 5a0f00 7fff 8001 exp 5a0f 0
test pat1_detect seq 32 9ac50000 1234 ffff seq 24 c3a500 0001 0000 exp c3a5 1
test pat2_detect seq 32 3d1b0000 2000 7fff seq 24 0ff000 4000 8000 exp 0ff0 2
test one_wrong_sign seq 32 3d1a0000 0100 0010 seq 24 6e2100 3fff 1111 exp 6e21 2
test two_wrong_signs seq 32 3d180000 0400 0000 seq 16 0000 0400 0000
test tie_low_index seq 32 9ac70000 0800 0200 seq 24 0ff000 0055 0000 exp 0ff0 0
test no_retrigger seq 32 9ac60000 0400 0123 seq 24 9ac600 0600 0abc exp 9ac6 0
test back_to_back seq 32 3d1b0000 0700 0000 seq 24 c3a500 0700 0000 exp c3a5 2
seq 32 9ac50000 0700 0000 seq 24 6e2100 0700 0000 exp 6e21 1

//--- dv/ssb_sync_tb.sv
`timescale 1ns/1ps

`include "ssb_sync_params.svh"

module ssb_sync_tb;

    localparam int DW      = `SSB_SAMPLE_DW;
    localparam int SSS_LEN = `SSB_SSS_LEN;
    localparam int DRAIN   = 200;  // quiet cycles after the last result

    logic               clk_i;
    logic               reset_ni;
    logic [DW-1:0]      sample_re_i;
    logic [DW-1:0]      sample_im_i;
    logic               sample_valid_i;
    logic               sample_ready_o;
    logic [SSS_LEN-1:0] sss_bits_o;
    logic [1:0]         nid2_o;
    logic               result_valid_o;
    logic               result_ready_i;

    string              names[$];
    logic [DW-1:0]      re_q[$];
    logic [DW-1:0]      im_q[$];
    logic [SSS_LEN-1:0] exp_bits_q[$];
    logic [1:0]         exp_nid2_q[$];
    int                 exp_test_q[$];
    logic [31:0]        rng;
    logic               accepted;
    int                 sent;
    int                 got;
    int                 stall;  // cycles left with result ready held low
    int                 cycles;
    int                 idle;
    int                 limit;

    ssb_sync_top dut_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_re_i    (sample_re_i),
        .sample_im_i    (sample_im_i),
        .sample_valid_i (sample_valid_i),
        .sample_ready_o (sample_ready_o),
        .sss_bits_o     (sss_bits_o),
        .nid2_o         (nid2_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic load_tests();
        int                 fd;
        int                 code;
        int                 cnt;
        string              tok;
        logic [8*128-1:0]   line;
        logic [31:0]        bits;
        logic [DW-1:0]      mag;
        logic [DW-1:0]      im;
        logic [SSS_LEN-1:0] word;
        logic [1:0]         nid2;
        fd = $fopen("dv/ssb_sync_tests.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open dv/ssb_sync_tests.txt");
            stop_run();
        end
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok == "#") begin
                code = $fgets(line, fd);
            end else if (tok == "test") begin
                code = $fscanf(fd, "%s", tok);
                names.push_back(tok);
            end else if (tok == "seq") begin
                code = $fscanf(fd, "%d %h %h %h", cnt, bits, mag, im);
                for (int i = 0; i < cnt; i++) begin
                    re_q.push_back(bits[i] ? mag : ~mag + 16'd1);  // bit 0 is negative
                    im_q.push_back(im);
                end
            end else if (tok == "exp") begin
                code = $fscanf(fd, "%h %h", word, nid2);
                exp_bits_q.push_back(word);
                exp_nid2_q.push_back(nid2);
                exp_test_q.push_back(names.size() - 1);
            end else begin
                $display("unknown keyword %s in the test file", tok);
                stop_run();
            end
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
    endtask

    // called on the falling edge, a presented sample stays until it is taken
    task automatic drive_inputs();
        if (!sample_valid_i || accepted) begin
            rng = xorshift32(rng);
            sample_valid_i = (sent < re_q.size()) && (rng[1:0] != 2'b00);
            if (sample_valid_i) begin
                sample_re_i = re_q[sent];
                sample_im_i = im_q[sent];
            end
        end
        rng = xorshift32(rng);
        if (stall > 0) begin
            result_ready_i = 1'b0;
            stall--;
        end else begin
            result_ready_i = rng[0] | rng[1];
            if (rng[7:4] == 4'd0) begin
                stall = int'(rng[13:8]);  // long hold to back up the SSS link
            end
        end
    endtask

    task automatic check_result();
        assert (got < exp_bits_q.size()) else begin
            $display("a result arrived after all %0d expected ones", exp_bits_q.size());
            stop_run();
        end
        if (result_ready_i) begin
            assert (sss_bits_o == exp_bits_q[got] && nid2_o == exp_nid2_q[got]) else begin
                $display("mismatch: test %s expected bits %h nid2 %0d, actual bits %h nid2 %0d",
                         names[exp_test_q[got]], exp_bits_q[got], exp_nid2_q[got],
                         sss_bits_o, nid2_o);
                stop_run();
            end
            got++;
        end
    endtask

    initial begin
        clk_i          = 1'b0;
        reset_ni       = 1'b0;
        sample_re_i    = '0;
        sample_im_i    = '0;
        sample_valid_i = 1'b0;
        result_ready_i = 1'b0;
        rng            = 32'd5;
        accepted       = 1'b0;
        sent           = 0;
        got            = 0;
        stall          = 0;
        cycles         = 0;
        idle           = 0;
        load_tests();
        limit = re_q.size() * 8 + 1000;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        reset_ni = 1'b1;
        while (sent < re_q.size() || got < exp_bits_q.size() || idle < DRAIN) begin
            drive_inputs();
            @(posedge clk_i);
            accepted = sample_valid_i && sample_ready_o;
            if (accepted) begin
                sent++;
            end
            if (result_valid_o) begin
                check_result();
            end
            if (sent == re_q.size() && got == exp_bits_q.size()) begin
                idle++;
            end
            cycles++;
            assert (cycles < limit) else begin
                $display("timeout, no result arrived within %0d cycles", limit);
                stop_run();
            end
            @(negedge clk_i);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- dv/ssb_sync_checker.sv
`timescale 1ns/1ps

`include "ssb_sync_params.svh"

module ssb_sync_checker
    import ssb_sync_pkg::*;
(
    input logic                     clk_i,
    input logic                     reset_ni,
    input logic                     sample_ready_i,
    input logic [`SSB_SSS_LEN-1:0]  result_bits_i,
    input logic [1:0]               result_nid2_i,
    input logic                     result_valid_i,
    input logic                     result_ready_i,
    input fs_state_e                fs_state_i
);

    // a held result keeps its data until it is taken
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        result_valid_i && !result_ready_i |=>
            result_valid_i && $stable(result_bits_i) && $stable(result_nid2_i))
        else $error("result changed before it was accepted");

    assert property (@(posedge clk_i) !reset_ni |=> !result_valid_i)
        else $error("result valid during reset");

    // input only stalls while SSS bits are being forwarded
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        $past(reset_ni) && (fs_state_i != FS_COLLECT) |-> sample_ready_i)
        else $error("sample ready low outside the SSS window");

endmodule

bind ssb_sync_top ssb_sync_checker u_checker (
    .clk_i          (clk_i),
    .reset_ni       (reset_ni),
    .sample_ready_i (sample_ready_o),
    .result_bits_i  (sss_bits_o),
    .result_nid2_i  (nid2_o),
    .result_valid_i (result_valid_o),
    .result_ready_i (result_ready_i),
    .fs_state_i     (u_frame_sync.state_q)
);

//--- rtl/ssb_sync_top.sv
`timescale 1ns/1ps

`include "ssb_sync_params.svh"

module ssb_sync_top
    import ssb_sync_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic [`SSB_SAMPLE_DW-1:0]  sample_re_i,
    input  logic [`SSB_SAMPLE_DW-1:0]  sample_im_i,
    input  logic                       sample_valid_i,
    output logic                       sample_ready_o,
    output logic [`SSB_SSS_LEN-1:0]    sss_bits_o,
    output nid2_t                      nid2_o,
    output logic                       result_valid_o,
    input  logic                       result_ready_i
);

    sample_t sample;
    logic    accept;
    logic    sign;
    logic    search_en;
    logic    peak;
    nid2_t   peak_nid2;

    sss_if u_sss_if ();

    assign sample = '{re: sample_re_i, im: sample_im_i};

    pss_detector u_pss_detector (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .accept_i    (accept),
        .sign_i      (sign),
        .search_en_i (search_en),
        .peak_o      (peak),
        .nid2_o      (peak_nid2)
    );

    frame_sync u_frame_sync (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sample_i    (sample),
        .valid_i     (sample_valid_i),
        .ready_o     (sample_ready_o),
        .accept_o    (accept),
        .sign_o      (sign),
        .search_en_o (search_en),
        .peak_i      (peak),
        .nid2_i      (peak_nid2),
        .sss         (u_sss_if.src)
    );

    sss_collector u_sss_collector (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sss            (u_sss_if.dst),
        .sss_bits_o     (sss_bits_o),
        .nid2_o         (nid2_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

endmodule

//--- rtl/sss_collector.sv
`timescale 1ns/1ps

`include "ssb_sync_params.svh"

module sss_collector
    import ssb_sync_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     reset_ni,
    sss_if.dst                       sss,
    output logic [`SSB_SSS_LEN-1:0]  sss_bits_o,
    output nid2_t                    nid2_o,
    output logic                     result_valid_o,
    input  logic                     result_ready_i
);

    localparam int LEN = `SSB_SSS_LEN;

    sc_state_e      state_q;
    logic [LEN-1:0] word_q;
    logic           xfer;

    assign xfer           = sss.valid && sss.ready;
    assign sss.ready      = (state_q == SC_COLLECT);  // no bits taken while a result waits
    assign result_valid_o = (state_q == SC_HOLD);
    assign sss_bits_o     = word_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= SC_COLLECT;
        end else begin
            case (state_q)
                SC_COLLECT: begin
                    if (xfer && sss.last) begin
                        state_q <= SC_HOLD;
                    end
                end
                SC_HOLD: begin
                    if (result_ready_i) begin
                        state_q <= SC_COLLECT;
                    end
                end
                default: state_q <= SC_COLLECT;
            endcase
        end
    end

    // shift in from the top so the first bit ends in bit 0
    always_ff @(posedge clk_i) begin
        if (xfer) begin
            word_q <= {sss.data_bit, word_q[LEN-1:1]};
            if (sss.last) begin
                nid2_o <= sss.nid2;
            end
        end
    end

endmodule

//--- rtl/frame_sync.sv
`timescale 1ns/1ps

`include "ssb_sync_params.svh"

module frame_sync
    import ssb_sync_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,
    input  sample_t sample_i,
    input  logic    valid_i,
    output logic    ready_o,
    output logic    accept_o,
    output logic    sign_o,
    output logic    search_en_o,
    input  logic    peak_i,
    input  nid2_t   nid2_i,
    sss_if.src      sss
);

    localparam int CNT_W = $clog2(`SSB_SSS_GAP + `SSB_SSS_LEN);

    fs_state_e        state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             run_q;  // low until the first cycle out of reset
    nid2_t            nid2_q;
    logic             drain;
    logic             load;

    assign drain = sss.valid && sss.ready;
    assign load  = (state_q == FS_COLLECT) && accept_o;

    // stall only while the SSS slot is full and not draining
    assign ready_o     = run_q && ((state_q != FS_COLLECT) || !sss.valid || sss.ready);
    assign accept_o    = valid_i && ready_o;
    assign sign_o      = ~sample_i.re[`SSB_SAMPLE_DW-1];  // 1 = non-negative
    assign search_en_o = (state_q == FS_SEARCH) && !peak_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q   <= FS_SEARCH;
            cnt_q     <= '0;
            run_q     <= 1'b0;
            sss.valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (load) begin
                sss.valid <= 1'b1;
            end else if (drain) begin
                sss.valid <= 1'b0;
            end
            case (state_q)
                FS_SEARCH: begin
                    if (peak_i) begin
                        state_q <= FS_SKIP;
                        cnt_q   <= accept_o ? CNT_W'(1) : '0;  // sample 1 may arrive now
                    end
                end
                FS_SKIP: begin
                    if (accept_o) begin
                        if (cnt_q == CNT_W'(`SSB_SSS_GAP - 1)) begin
                            state_q <= FS_COLLECT;
                            cnt_q   <= '0;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                FS_COLLECT: begin
                    if (accept_o) begin
                        if (cnt_q == CNT_W'(`SSB_SSS_LEN - 1)) begin
                            state_q <= FS_SEARCH;
                            cnt_q   <= '0;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= FS_SEARCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (peak_i && (state_q == FS_SEARCH)) begin
            nid2_q <= nid2_i;
        end
        if (load) begin
            sss.data_bit <= sign_o;  // inverted sign bit of the real part
            sss.last     <= (cnt_q == CNT_W'(`SSB_SSS_LEN - 1));
            sss.nid2     <= nid2_q;
        end
    end

endmodule

//--- rtl/pss_detector.sv
`timescale 1ns/1ps

`include "ssb_sync_params.svh"

module pss_detector
    import ssb_sync_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_ni,
    input  logic  accept_i,
    input  logic  sign_i,
    input  logic  search_en_i,
    output logic  peak_o,
    output nid2_t nid2_o
);

    localparam int LEN     = `SSB_PSS_LEN;
    localparam int SCORE_W = $clog2(LEN + 1);

    localparam logic [LEN-1:0] PATS [0:2] = '{
        `SSB_PSS_PAT_0,
        `SSB_PSS_PAT_1,
        `SSB_PSS_PAT_2
    };

    logic [LEN-1:0]     hist_q;  // bit 0 holds the oldest sign
    logic [LEN-1:0]     win;
    logic [SCORE_W-1:0] score [0:2];
    logic [SCORE_W-1:0] best_score;
    nid2_t              best_idx;
    logic               hit;

    // number of positions where the window sign equals the pattern
    function automatic logic [SCORE_W-1:0] match_count(
        input logic [LEN-1:0] w,
        input logic [LEN-1:0] pat
    );
        logic [SCORE_W-1:0] cnt;
        logic [LEN-1:0]     eq;
        cnt = '0;
        eq  = ~(w ^ pat);
        for (int j = 0; j < LEN; j++) begin
            cnt = cnt + SCORE_W'(eq[j]);
        end
        return cnt;
    endfunction

    // window including the sample accepted this cycle
    assign win = accept_i ? {sign_i, hist_q[LEN-1:1]} : hist_q;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            score[i] = match_count(win, PATS[i]);
        end
        best_idx   = 2'd0;
        best_score = score[0];
        for (int i = 1; i < 3; i++) begin
            if (score[i] > best_score) begin  // strict, lowest index wins a tie
                best_score = score[i];
                best_idx   = nid2_t'(i);
            end
        end
    end

    assign hit = best_score >= SCORE_W'(`SSB_PSS_THRESH);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            hist_q <= '0;
            peak_o <= 1'b0;
        end else begin
            if (accept_i) begin
                hist_q <= win;
            end
            peak_o <= accept_i && search_en_i && hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            nid2_o <= best_idx;
        end
    end

endmodule

//--- rtl/sss_if.sv
`timescale 1ns/1ps

// windowed SSS bits from frame sync to the collector
interface sss_if
    import ssb_sync_pkg::*;
();

    logic  data_bit;  // BPSK decision
    logic  last;
    nid2_t nid2;
    logic  valid;
    logic  ready;

    modport src (
        output data_bit, last, nid2, valid,
        input  ready
    );

    modport dst (
        input  data_bit, last, nid2, valid,
        output ready
    );

endinterface

//--- rtl/ssb_sync_pkg.sv
`include "ssb_sync_params.svh"

package ssb_sync_pkg;

    // complex sample, real part in the upper half
    typedef struct packed {
        logic signed [`SSB_SAMPLE_DW-1:0] re;
        logic signed [`SSB_SAMPLE_DW-1:0] im;
    } sample_t;

    typedef logic [1:0] nid2_t;

    typedef enum logic [1:0] {
        FS_SEARCH,
        FS_SKIP,    // gap between PSS and SSS
        FS_COLLECT
    } fs_state_e;

    typedef enum logic {
        SC_COLLECT,
        SC_HOLD     // result waiting for the consumer
    } sc_state_e;

endpackage

//--- rtl/ssb_sync_params.svh
`ifndef SSB_SYNC_PARAMS_SVH
`define SSB_SYNC_PARAMS_SVH

// width of the real and of the imaginary part
`define SSB_SAMPLE_DW 16

// correlation window in samples
`define SSB_PSS_LEN 16

// bit j is the expected sign of the j-th oldest sample, 1 = non-negative
`define SSB_PSS_PAT_0 16'h9AC6
`define SSB_PSS_PAT_1 16'h9AC5
`define SSB_PSS_PAT_2 16'h3D1B

`define SSB_PSS_THRESH 15  // min sign matches for a peak

// accepted samples skipped after the peak sample
`define SSB_SSS_GAP 8

`define SSB_SSS_LEN 16  // SSS samples, one bit each

`endif
